/* common/mem_geom_pkg.sv */
package mem_geom_pkg;

  // data path
  localparam int DEF_WIDTH = 16;

  // port count, one full memory copy per read port
  localparam int DEF_NUMRDPT = 2;

  // copy geometry
  localparam int DEF_NUMVBNK = 4;   // banks per copy
  localparam int DEF_NUMVROW = 64;  // rows per bank
  localparam int DEF_NUMADDR = 256; // must not exceed NUMVBNK * NUMVROW

  // pipeline
  localparam int DEF_SRAM_DELAY = 2; // bank read latency in cycles
  localparam int DEF_FLOPIN = 1;     // input register stage
  localparam int DEF_FLOPOUT = 1;    // output register stage

endpackage

/* common/mem_op_pkg.sv */
package mem_op_pkg;

  // command seen by one bank copy in one cycle
  // bit 1 is the write part, bit 0 the read part
  typedef enum logic [1:0] {
    BANK_IDLE  = 2'b00,
    BANK_READ  = 2'b01,
    BANK_WRITE = 2'b10,
    BANK_RDWR  = 2'b11
  } bank_op_e;

endpackage

/* source/addr_map.sv */
`timescale 1ns/1ps

module addr_map #(
  parameter int WIDTH = 16,
  parameter int NUMRDPT = 2,
  parameter int NUMVBNK = 4,
  parameter int NUMVROW = 64,
  parameter int NUMADDR = 256,
  parameter int FLOPIN = 1,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1,
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1
) (
  input  logic                                rd_clk,
  input  logic                                wr_rst,
  input  logic                                write,
  input  logic [BITADDR-1:0]                  wr_adr,
  input  logic [WIDTH-1:0]                    din,
  input  logic [WIDTH-1:0]                    bw,
  input  logic [NUMRDPT-1:0]                  read,
  input  logic [NUMRDPT*BITADDR-1:0]          rd_adr,
  output mem_op_pkg::bank_op_e [NUMRDPT-1:0]  bank_op,
  output logic [BITVBNK-1:0]                  wr_bank,
  output logic [BITVROW-1:0]                  wr_row,
  output logic [WIDTH-1:0]                    wr_din,
  output logic [WIDTH-1:0]                    wr_bw,
  output logic [NUMRDPT-1:0]                  rd_req,
  output logic [NUMRDPT*BITVBNK-1:0]          rd_bank,
  output logic [NUMRDPT*BITVROW-1:0]          rd_row
);

  import mem_op_pkg::*;

  logic                       write_q;
  logic [BITADDR-1:0]         wr_adr_q;
  logic [NUMRDPT-1:0]         read_q;
  logic [NUMRDPT*BITADDR-1:0] rd_adr_q;

  if (FLOPIN != 0) begin : g_flopin
    always_ff @(posedge rd_clk) begin
      if (wr_rst) begin
        write_q <= 1'b0;
        read_q  <= '0;
      end else begin
        write_q <= write;
        read_q  <= read;
      end
    end

    always_ff @(posedge rd_clk) begin
      wr_adr_q <= wr_adr;
      wr_din   <= din;
      wr_bw    <= bw;
      rd_adr_q <= rd_adr;
    end
  end else begin : g_noflop
    assign write_q  = write;
    assign read_q   = read;
    assign wr_adr_q = wr_adr;
    assign wr_din   = din;
    assign wr_bw    = bw;
    assign rd_adr_q = rd_adr;
  end

  // banks interleave on the low address bits
  assign wr_bank = BITVBNK'(wr_adr_q % NUMVBNK);
  assign wr_row  = BITVROW'(wr_adr_q / NUMVBNK);
  assign rd_req  = read_q;

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_port
    logic [BITADDR-1:0] adr;

    assign adr = rd_adr_q[p*BITADDR +: BITADDR];
    assign rd_bank[p*BITVBNK +: BITVBNK] = BITVBNK'(adr % NUMVBNK);
    assign rd_row[p*BITVROW +: BITVROW]  = BITVROW'(adr / NUMVBNK);
  end

  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      case ({write_q, read_q[p]})
        2'b11:   bank_op[p] = BANK_RDWR;
        2'b10:   bank_op[p] = BANK_WRITE; // write lands in this copy too
        2'b01:   bank_op[p] = BANK_READ;
        default: bank_op[p] = BANK_IDLE;
      endcase
    end
  end

endmodule

/* bank_array/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram #(
  parameter int WIDTH = 16,
  parameter int NUMVROW = 64,
  parameter int SRAM_DELAY = 2,
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1
) (
  input  logic               rd_clk,
  input  logic               writeA,
  input  logic [BITVROW-1:0] addrA,
  input  logic [WIDTH-1:0]   dinA,
  input  logic [WIDTH-1:0]   bwA,
  input  logic               readB,
  input  logic [BITVROW-1:0] addrB,
  output logic [WIDTH-1:0]   doutB
);

  logic [WIDTH-1:0] mem [NUMVROW];

  // masked write, untouched bits keep their value
  always_ff @(posedge rd_clk) begin
    if (writeA) begin
      mem[addrA] <= (mem[addrA] & ~bwA) | (dinA & bwA);
    end
  end

  if (SRAM_DELAY == 0) begin : g_comb
    assign doutB = readB ? mem[addrB] : '0;
  end else begin : g_pipe
    logic [WIDTH-1:0] pipe [SRAM_DELAY];

    always_ff @(posedge rd_clk) begin
      if (readB) begin
        pipe[0] <= mem[addrB]; // sees the row before this edge's write
      end
      for (int i = 1; i < SRAM_DELAY; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end

    assign doutB = pipe[SRAM_DELAY-1];
  end

endmodule

/* bank_array/bank_array.sv */
`timescale 1ns/1ps

module bank_array #(
  parameter int WIDTH = 16,
  parameter int NUMRDPT = 2,
  parameter int NUMVBNK = 4,
  parameter int NUMVROW = 64,
  parameter int SRAM_DELAY = 2,
  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1,
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1
) (
  input  logic                                rd_clk,
  input  mem_op_pkg::bank_op_e [NUMRDPT-1:0]  bank_op,
  input  logic [BITVBNK-1:0]                  wr_bank,
  input  logic [BITVROW-1:0]                  wr_row,
  input  logic [WIDTH-1:0]                    wr_din,
  input  logic [WIDTH-1:0]                    wr_bw,
  input  logic [NUMRDPT*BITVBNK-1:0]          rd_bank,
  input  logic [NUMRDPT*BITVROW-1:0]          rd_row,
  output logic [NUMRDPT*NUMVBNK*WIDTH-1:0]    bank_dout
);

  import mem_op_pkg::*;

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_copy
    logic               wr_en;
    logic               rd_en;
    logic [BITVBNK-1:0] rbank;
    logic [BITVROW-1:0] rrow;

    // every copy gets the write, only copy p serves port p
    assign wr_en = (bank_op[p] == BANK_WRITE) || (bank_op[p] == BANK_RDWR);
    assign rd_en = (bank_op[p] == BANK_READ) || (bank_op[p] == BANK_RDWR);
    assign rbank = rd_bank[p*BITVBNK +: BITVBNK];
    assign rrow  = rd_row[p*BITVROW +: BITVROW];

    for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
      bank_ram #(
        .WIDTH      (WIDTH),
        .NUMVROW    (NUMVROW),
        .SRAM_DELAY (SRAM_DELAY)
      ) i_bank_ram (
        .rd_clk (rd_clk),
        .writeA (wr_en && (wr_bank == BITVBNK'(b))),
        .addrA  (wr_row),
        .dinA   (wr_din),
        .bwA    (wr_bw),
        .readB  (rd_en && (rbank == BITVBNK'(b))),
        .addrB  (rrow),
        .doutB  (bank_dout[(b*NUMRDPT+p)*WIDTH +: WIDTH]) // bank major, port minor
      );
    end
  end

endmodule

/* source/read_return.sv */
`timescale 1ns/1ps

module read_return #(
  parameter int WIDTH = 16,
  parameter int NUMRDPT = 2,
  parameter int NUMVBNK = 4,
  parameter int SRAM_DELAY = 2,
  parameter int FLOPOUT = 1,
  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1
) (
  input  logic                             rd_clk,
  input  logic                             wr_rst,
  input  logic [NUMRDPT-1:0]               rd_req,
  input  logic [NUMRDPT*BITVBNK-1:0]       rd_bank,
  input  logic [NUMRDPT*NUMVBNK*WIDTH-1:0] bank_dout,
  output logic [NUMRDPT-1:0]               rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]         rd_dout
);

  logic [NUMRDPT-1:0]         req_dly  [SRAM_DELAY+1];
  logic [NUMRDPT*BITVBNK-1:0] bank_dly [SRAM_DELAY+1];
  logic [NUMRDPT*WIDTH-1:0]   sel_dout;

  assign req_dly[0]  = rd_req;
  assign bank_dly[0] = rd_bank;

  // track each request alongside the sram pipe
  for (genvar s = 0; s < SRAM_DELAY; s++) begin : g_dly
    always_ff @(posedge rd_clk) begin
      if (wr_rst) begin
        req_dly[s+1] <= '0;
      end else begin
        req_dly[s+1] <= req_dly[s];
      end
    end

    always_ff @(posedge rd_clk) begin
      bank_dly[s+1] <= bank_dly[s];
    end
  end

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_sel
    logic [BITVBNK-1:0] bnk;

    assign bnk = bank_dly[SRAM_DELAY][p*BITVBNK +: BITVBNK];
    assign sel_dout[p*WIDTH +: WIDTH] = bank_dout[(int'(bnk)*NUMRDPT+p)*WIDTH +: WIDTH];
  end

  if (FLOPOUT != 0) begin : g_flopout
    always_ff @(posedge rd_clk) begin
      if (wr_rst) begin
        rd_vld <= '0;
      end else begin
        rd_vld <= req_dly[SRAM_DELAY];
      end
    end

    always_ff @(posedge rd_clk) begin
      rd_dout <= sel_dout;
    end
  end else begin : g_noflop
    assign rd_vld  = req_dly[SRAM_DELAY];
    assign rd_dout = sel_dout;
  end

endmodule

/* source/nr1w_dup_top.sv */
`timescale 1ns/1ps

module nr1w_dup_top #(
  parameter int WIDTH = mem_geom_pkg::DEF_WIDTH,
  parameter int NUMRDPT = mem_geom_pkg::DEF_NUMRDPT,
  parameter int NUMVBNK = mem_geom_pkg::DEF_NUMVBNK,
  parameter int NUMVROW = mem_geom_pkg::DEF_NUMVROW,
  parameter int NUMADDR = mem_geom_pkg::DEF_NUMADDR,
  parameter int SRAM_DELAY = mem_geom_pkg::DEF_SRAM_DELAY,
  parameter int FLOPIN = mem_geom_pkg::DEF_FLOPIN,
  parameter int FLOPOUT = mem_geom_pkg::DEF_FLOPOUT,
  localparam int BITADDR = $clog2(NUMADDR)
) (
  input  logic                       rd_clk,
  input  logic                       wr_rst,
  input  logic                       write,
  input  logic [BITADDR-1:0]         wr_adr,
  input  logic [WIDTH-1:0]           din,
  input  logic [WIDTH-1:0]           bw,
  input  logic [NUMRDPT-1:0]         read,
  input  logic [NUMRDPT*BITADDR-1:0] rd_adr,
  output logic [NUMRDPT-1:0]         rd_vld,
  output logic [NUMRDPT*WIDTH-1:0]   rd_dout
);

  import mem_op_pkg::*;

  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1;
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1;

  bank_op_e [NUMRDPT-1:0]           bank_op;
  logic [BITVBNK-1:0]               wr_bank;
  logic [BITVROW-1:0]               wr_row;
  logic [WIDTH-1:0]                 wr_din;
  logic [WIDTH-1:0]                 wr_bw;
  logic [NUMRDPT-1:0]               rd_req;
  logic [NUMRDPT*BITVBNK-1:0]       rd_bank;
  logic [NUMRDPT*BITVROW-1:0]       rd_row;
  logic [NUMRDPT*NUMVBNK*WIDTH-1:0] bank_dout;

  addr_map #(
    .WIDTH   (WIDTH),
    .NUMRDPT (NUMRDPT),
    .NUMVBNK (NUMVBNK),
    .NUMVROW (NUMVROW),
    .NUMADDR (NUMADDR),
    .FLOPIN  (FLOPIN)
  ) i_addr_map (
    .rd_clk  (rd_clk),
    .wr_rst  (wr_rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .read    (read),
    .rd_adr  (rd_adr),
    .bank_op (bank_op),
    .wr_bank (wr_bank),
    .wr_row  (wr_row),
    .wr_din  (wr_din),
    .wr_bw   (wr_bw),
    .rd_req  (rd_req),
    .rd_bank (rd_bank),
    .rd_row  (rd_row)
  );

  bank_array #(
    .WIDTH      (WIDTH),
    .NUMRDPT    (NUMRDPT),
    .NUMVBNK    (NUMVBNK),
    .NUMVROW    (NUMVROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) i_bank_array (
    .rd_clk    (rd_clk),
    .bank_op   (bank_op),
    .wr_bank   (wr_bank),
    .wr_row    (wr_row),
    .wr_din    (wr_din),
    .wr_bw     (wr_bw),
    .rd_bank   (rd_bank),
    .rd_row    (rd_row),
    .bank_dout (bank_dout)
  );

  read_return #(
    .WIDTH      (WIDTH),
    .NUMRDPT    (NUMRDPT),
    .NUMVBNK    (NUMVBNK),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPOUT    (FLOPOUT)
  ) i_read_return (
    .rd_clk    (rd_clk),
    .wr_rst    (wr_rst),
    .rd_req    (rd_req),
    .rd_bank   (rd_bank),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 40,
  parameter int RST_CYCLES = 8,
  parameter int DRIVE_DLY = 2
) (
  output logic rd_clk,
  output logic wr_rst
);

  initial begin
    rd_clk = 1'b0;
    forever begin
      #(PERIOD / 2) rd_clk = ~rd_clk;
    end
  end

  initial begin
    wr_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge rd_clk);
    #(DRIVE_DLY) wr_rst = 1'b0; // released off the edge like the other inputs
  end

endmodule

/* verification/mem_monitor.sv */
`timescale 1ns/1ps

module mem_monitor #(
  parameter int WIDTH = 16,
  parameter int NUMRDPT = 2,
  parameter int NUMVBNK = 4,
  parameter int NUMVROW = 64,
  parameter int NUMADDR = 256,
  parameter int FLOPIN = 1,
  parameter int LATENCY = 4,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int BITVBNK = (NUMVBNK > 1) ? $clog2(NUMVBNK) : 1,
  localparam int BITVROW = (NUMVROW > 1) ? $clog2(NUMVROW) : 1
) (
  input  logic                               rd_clk,
  input  mem_op_pkg::bank_op_e [NUMRDPT-1:0] bank_op,
  input  logic [BITVBNK-1:0]                 wr_bank,
  input  logic [BITVROW-1:0]                 wr_row,
  input  logic [WIDTH-1:0]                   wr_din,
  input  logic [WIDTH-1:0]                   wr_bw,
  input  logic [NUMRDPT-1:0]                 read,
  input  logic [NUMRDPT*BITADDR-1:0]         rd_adr,
  input  logic [NUMRDPT-1:0]                 rd_vld,
  input  logic [NUMRDPT*WIDTH-1:0]           rd_dout,
  input  logic [BITADDR-1:0]                 sel_adr,
  input  int                                 sel_bit,
  output logic                               err,
  output int                                 hits
);

  import mem_op_pkg::*;

  typedef struct packed {
    logic chk; // selected bit known when the read went in
    logic val;
  } tap_t;
  typedef tap_t [NUMRDPT-1:0] tap_row_t;

  logic     sel_known;
  logic     sel_val;
  tap_row_t tap_q [$];

  function automatic bit is_write(input bank_op_e op);
    return op inside {BANK_WRITE, BANK_RDWR};
  endfunction

  // every copy must see the same write to the selected bit
  task automatic take_write();
    for (int p = 1; p < NUMRDPT; p++) begin
      assert (is_write(bank_op[p]) == is_write(bank_op[0])) else begin
        $display("write to copy %0d does not match copy 0 at %0t", p, $time);
        err = 1'b1;
      end
    end
    if (is_write(bank_op[0]) && int'(wr_bank) == int'(sel_adr) % NUMVBNK &&
        int'(wr_row) == int'(sel_adr) / NUMVBNK && wr_bw[sel_bit]) begin
      sel_known = 1'b1;
      sel_val   = wr_din[sel_bit];
    end
  endtask

  initial begin
    err       = 1'b0;
    hits      = 0;
    sel_known = 1'b0;
    sel_val   = 1'b0;
    for (int i = 0; i < LATENCY; i++) begin
      tap_q.push_back('0);
    end
  end

  always @(negedge rd_clk) begin : track
    tap_row_t row;
    tap_row_t due;
    due = tap_q.pop_front();
    for (int p = 0; p < NUMRDPT; p++) begin
      if (due[p].chk) begin
        hits++;
        assert (rd_vld[p] && rd_dout[p*WIDTH + sel_bit] === due[p].val) else begin
          $display("error: time %0t rd_dout[%0d] bit %0d expected %0b got %0b", $time, p,
                   sel_bit, due[p].val, rd_dout[p*WIDTH + sel_bit]);
          err = 1'b1;
        end
      end
    end
    if (FLOPIN != 0) begin
      take_write(); // a read sampled now reaches the bank one edge later
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      row[p].chk = read[p] && (rd_adr[p*BITADDR +: BITADDR] == sel_adr) && sel_known;
      row[p].val = sel_val;
    end
    if (FLOPIN == 0) begin
      take_write();
    end
    tap_q.push_back(row);
  end

endmodule

/* verification/tb_nr1w.sv */
`timescale 1ns/1ps

module tb_nr1w;

  import mem_geom_pkg::*;

  localparam int WIDTH = DEF_WIDTH;
  localparam int NUMRDPT = DEF_NUMRDPT;
  localparam int NUMADDR = DEF_NUMADDR;
  localparam int BITADDR = $clog2(NUMADDR);
  localparam int LATENCY = DEF_FLOPIN + DEF_SRAM_DELAY + DEF_FLOPOUT;
  localparam int NUM_CYCLES = 3000;
  localparam int IDLE_CYCLES = 16;
  localparam int PHASE_LEN = 400;
  localparam int MAX_WAIT = 100;
  localparam int DRIVE_DLY = 2;

  typedef struct packed {
    logic             vld;
    logic [WIDTH-1:0] data;
    logic [WIDTH-1:0] known; // bits written at least once
  } exp_t;
  typedef exp_t [NUMRDPT-1:0] exp_row_t;

  logic                       rd_clk;
  logic                       wr_rst;
  logic                       write;
  logic [BITADDR-1:0]         wr_adr;
  logic [WIDTH-1:0]           din;
  logic [WIDTH-1:0]           bw;
  logic [NUMRDPT-1:0]         read;
  logic [NUMRDPT*BITADDR-1:0] rd_adr;
  logic [NUMRDPT-1:0]         rd_vld;
  logic [NUMRDPT*WIDTH-1:0]   rd_dout;
  logic                       mon_err;
  int                         mon_hits;

  logic [WIDTH-1:0]   model_mem [int];
  logic [WIDTH-1:0]   model_wrt [int];
  exp_row_t           exp_q [$];
  logic [31:0]        rng;
  logic [BITADDR-1:0] sel_adr;
  logic [BITADDR-1:0] win_base;
  int                 sel_bit;
  int                 pending; // reads still in flight
  int                 data_checks;

  tb_clock #(.PERIOD(40), .RST_CYCLES(8), .DRIVE_DLY(DRIVE_DLY)) i_tb_clock (
    .rd_clk (rd_clk),
    .wr_rst (wr_rst)
  );

  nr1w_dup_top #(
    .WIDTH      (WIDTH),
    .NUMRDPT    (NUMRDPT),
    .NUMVBNK    (DEF_NUMVBNK),
    .NUMVROW    (DEF_NUMVROW),
    .NUMADDR    (NUMADDR),
    .SRAM_DELAY (DEF_SRAM_DELAY),
    .FLOPIN     (DEF_FLOPIN),
    .FLOPOUT    (DEF_FLOPOUT)
  ) i_nr1w_dup_top (
    .rd_clk  (rd_clk),
    .wr_rst  (wr_rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .bw      (bw),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  mem_monitor #(
    .WIDTH   (WIDTH),
    .NUMRDPT (NUMRDPT),
    .NUMVBNK (DEF_NUMVBNK),
    .NUMVROW (DEF_NUMVROW),
    .NUMADDR (NUMADDR),
    .FLOPIN  (DEF_FLOPIN),
    .LATENCY (LATENCY)
  ) i_mem_monitor (
    .rd_clk  (rd_clk),
    .bank_op (i_nr1w_dup_top.bank_op),
    .wr_bank (i_nr1w_dup_top.wr_bank),
    .wr_row  (i_nr1w_dup_top.wr_row),
    .wr_din  (i_nr1w_dup_top.wr_din),
    .wr_bw   (i_nr1w_dup_top.wr_bw),
    .read    (read),
    .rd_adr  (rd_adr),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .sel_adr (sel_adr),
    .sel_bit (sel_bit),
    .err     (mon_err),
    .hits    (mon_hits)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [BITADDR-1:0] pick_adr(input bit narrow);
    logic [31:0] r;
    r = next_rand();
    if (narrow) begin
      return BITADDR'((win_base + r % 8) % NUMADDR); // small window for many collisions
    end
    return BITADDR'(r % NUMADDR);
  endfunction

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_outputs();
    exp_row_t         row;
    logic [WIDTH-1:0] got;
    row = exp_q.pop_front();
    for (int p = 0; p < NUMRDPT; p++) begin
      got = rd_dout[p*WIDTH +: WIDTH];
      assert (rd_vld[p] === row[p].vld) else begin
        $display("error: time %0t rd_vld[%0d] expected %0b got %0b", $time, p,
                 row[p].vld, rd_vld[p]);
        stop_run();
      end
      if (row[p].vld) begin
        pending--;
        data_checks++;
        assert (((got ^ row[p].data) & row[p].known) == '0) else begin
          $display("error: time %0t rd_dout[%0d] expected %h got %h (known bits %h)",
                   $time, p, row[p].data, got, row[p].known);
          stop_run();
        end
      end
    end
  endtask

  task automatic drive_random(input int n);
    logic [31:0] r;
    int          phase;
    bit          narrow;
    phase  = (n / PHASE_LEN) % 3; // uniform, window, window with every port reading
    narrow = (phase != 0);
    r      = next_rand();
    write  = r[0];
    wr_adr = pick_adr(narrow);
    din    = WIDTH'(next_rand());
    bw     = (r[2:1] == 2'b00) ? '1 : WIDTH'(next_rand());
    for (int p = 0; p < NUMRDPT; p++) begin
      r = next_rand();
      read[p] = (phase == 2) || (r[1:0] != 2'b00);
      if (narrow && r[3:2] == 2'b00) begin
        rd_adr[p*BITADDR +: BITADDR] = wr_adr; // read the word being written
      end else begin
        rd_adr[p*BITADDR +: BITADDR] = pick_adr(narrow);
      end
    end
  endtask

  task automatic drive_idle();
    write = 1'b0;
    read  = '0;
  endtask

  // a read sampled with a write sees the word before that write
  task automatic record_request();
    exp_row_t         row;
    int               a;
    logic [WIDTH-1:0] word;
    logic [WIDTH-1:0] wrt;
    for (int p = 0; p < NUMRDPT; p++) begin
      a = int'(rd_adr[p*BITADDR +: BITADDR]);
      row[p].vld   = read[p];
      row[p].data  = model_mem.exists(a) ? model_mem[a] : '0;
      row[p].known = model_wrt.exists(a) ? model_wrt[a] : '0;
      if (read[p]) begin
        pending++;
      end
    end
    exp_q.push_back(row);
    if (write) begin
      a = int'(wr_adr);
      if (!model_mem.exists(a)) begin
        model_mem[a] = '0;
        model_wrt[a] = '0;
      end
      word = model_mem[a];
      wrt  = model_wrt[a];
      for (int i = 0; i < WIDTH; i++) begin
        if (bw[i]) begin
          word[i] = din[i];
          wrt[i]  = 1'b1;
        end
      end
      model_mem[a] = word;
      model_wrt[a] = wrt;
    end
  endtask

  task automatic run_cycle(input bit active, input int n);
    @(posedge rd_clk);
    #(DRIVE_DLY);
    check_outputs();
    if (active) begin
      drive_random(n);
    end else begin
      drive_idle();
    end
    record_request();
  endtask

  always @(posedge mon_err) begin
    stop_run();
  end

  initial begin
    int wait_cnt;
    $timeformat(-9, 0, " ns", 0);
    write       = 1'b0;
    wr_adr      = '0;
    din         = '0;
    bw          = '0;
    read        = '0;
    rd_adr      = '0;
    rng         = 32'd42;
    pending     = 0;
    data_checks = 0;
    sel_adr     = BITADDR'(next_rand() % NUMADDR);
    sel_bit     = int'(next_rand() % WIDTH);
    win_base    = BITADDR'((sel_adr / 8) * 8); // window holds the monitored address
    for (int i = 0; i < LATENCY; i++) begin
      exp_q.push_back('0);
    end

    wait_cnt = 0;
    while (wr_rst !== 1'b0) begin
      @(posedge rd_clk);
      wait_cnt++;
      assert (wait_cnt <= MAX_WAIT) else begin
        $display("reset was never released");
        stop_run();
      end
    end

    // rd_vld must stay low through the idle cycles
    for (int n = 0; n < NUM_CYCLES; n++) begin
      run_cycle(n >= IDLE_CYCLES, n);
    end

    wait_cnt = 0;
    while (pending > 0) begin
      run_cycle(1'b0, 0);
      wait_cnt++;
      assert (wait_cnt <= MAX_WAIT) else begin
        $display("pipeline did not drain, %0d reads never returned", pending);
        stop_run();
      end
    end

    if (data_checks < NUM_CYCLES || mon_hits == 0) begin
      $display("too few reads were checked, %0d by the model and %0d by the monitor",
               data_checks, mon_hits);
      stop_run();
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* verilog.f */
common/mem_geom_pkg.sv
common/mem_op_pkg.sv
source/addr_map.sv
bank_array/bank_ram.sv
bank_array/bank_array.sv
source/read_return.sv
source/nr1w_dup_top.sv
verification/tb_clock.sv
verification/mem_monitor.sv
verification/tb_nr1w.sv

/* run.sh */
#!/bin/sh
# build and run the nR1W testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module tb_nr1w -f verilog.f \
  -o sim_nr1w > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_nr1w > sim.log 2>&1
cat sim.log
! grep -q '\*\* FAIL \*\*' sim.log && grep -q '\*\* PASS \*\*' sim.log
